/* adc_config/adc_config_seq.sv */
////////////////////
// ADC configuration sequencer
// Waits STARTUP_WAIT cycles after reset, then sends three init writes
// Afterwards serves one register write at a time
// Requests arriving while busy are dropped
////////////////////

`timescale 1ns/10ps

module adc_config_seq #(
	parameter int STARTUP_WAIT = 256      // Cycles before the first frame
) (
	input  logic                     clk_in,
	input  logic                     rst_in,
	input  logic                     reg_req,     // One-cycle request
	input  adc_ctrl_pkg::reg_addr_t  reg_addr,
	input  adc_ctrl_pkg::reg_data_t  reg_data,
	output logic                     spi_start,   // One-cycle start pulse
	output adc_ctrl_pkg::spi_word_t  spi_word,
	input  logic                     spi_ready
);

	localparam int CNT_W = $clog2(STARTUP_WAIT + 1);

	typedef enum logic [1:0] {
		S_WAIT,   // Power-up delay
		S_SEND,   // Wait for master, then start
		S_GAP,    // Start pulse ends
		S_IDLE    // Ready for user writes
	} seq_state_t;

	seq_state_t       state;
	logic [CNT_W-1:0] wait_cnt;   // Startup countdown
	logic [1:0]       init_idx;   // Init table position, 3 = done

	////////////////////
	// Init table

	function automatic adc_ctrl_pkg::spi_word_t init_word(input logic [1:0] idx);
		case (idx)
			2'd0:    init_word = {1'b0, 7'h00, 8'h80}; // Soft reset
			2'd1:    init_word = {1'b0, 7'h01, 8'h20}; // Two's complement out
			default: init_word = {1'b0, 7'h02, 8'h00}; // 2-lane mode
		endcase
	endfunction

	////////////////////
	// Sequencer FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= S_WAIT;
			wait_cnt  <= CNT_W'(STARTUP_WAIT);
			init_idx  <= 2'd0;
			spi_start <= 1'b0;
		end else begin
			case (state)
				S_WAIT: begin
					if (wait_cnt == '0)
						state <= S_SEND;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				S_SEND: begin
					if (spi_ready) begin
						spi_start <= 1'b1; // Master is free
						if (init_idx != 2'd3)
							init_idx <= init_idx + 1'b1;
						state <= S_GAP;
					end
				end
				S_GAP: begin
					spi_start <= 1'b0;
					// More init writes or go serve the host
					state <= (init_idx == 2'd3) ? S_IDLE : S_SEND;
				end
				default: begin // S_IDLE
					if (reg_req)
						state <= S_SEND;
				end
			endcase
		end
	end

	// Frame register, loaded with the start pulse or on a user request
	always_ff @(posedge clk_in) begin
		if (state == S_SEND && spi_ready && init_idx != 2'd3)
			spi_word <= init_word(init_idx);
		else if (state == S_IDLE && reg_req)
			spi_word <= {1'b0, reg_addr, reg_data}; // Write flag first
	end

endmodule

/* adc_config/spi_master.sv */
////////////////////
// SPI write master, 16-bit frames, MSB first
// sck idles low, sdo changes while sck is low
// Each sck half period is SPI_CLK_DIV clk_in cycles
// A start while not ready is ignored
////////////////////

`timescale 1ns/10ps

module spi_master #(
	parameter int SPI_CLK_DIV = 10         // Cycles per sck half period
) (
	input  logic                     clk_in,
	input  logic                     rst_in,
	input  logic                     spi_start,
	input  adc_ctrl_pkg::spi_word_t  spi_word,
	output logic                     spi_ready,
	output logic                     spi_scs,   // Chip select, active low
	output logic                     spi_sck,
	output logic                     spi_sdo
);

	localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);

	typedef enum logic [1:0] {
		M_IDLE,  // Waiting for a start
		M_LOW,   // sck low half
		M_HIGH,  // sck high half
		M_END    // Hold scs low after last bit
	} spi_state_t;

	spi_state_t              state;
	logic [DIV_W-1:0]        div_cnt;   // Half-period divider
	logic [3:0]              bit_cnt;   // Bits already shifted out
	adc_ctrl_pkg::spi_word_t shift_reg; // Remaining bits, next at MSB
	logic                    half_done;

	assign half_done = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
	assign spi_ready = (state == M_IDLE); // High again once scs is back up

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state   <= M_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			spi_scs <= 1'b1;
			spi_sck <= 1'b0;
			spi_sdo <= 1'b0;
		end else begin
			div_cnt <= half_done ? '0 : div_cnt + 1'b1;
			case (state)
				M_IDLE: begin
					div_cnt <= '0;
					if (spi_start) begin
						spi_scs <= 1'b0;
						spi_sdo <= spi_word[15]; // First bit ahead of the edge
						bit_cnt <= '0;
						state   <= M_LOW;
					end
				end
				M_LOW: if (half_done) begin
					spi_sck <= 1'b1; // Slave samples here
					state   <= M_HIGH;
				end
				M_HIGH: if (half_done) begin
					spi_sck <= 1'b0;
					if (bit_cnt == 4'd15) begin
						state <= M_END;
					end else begin
						spi_sdo <= shift_reg[15];
						bit_cnt <= bit_cnt + 1'b1;
						state   <= M_LOW;
					end
				end
				default: if (half_done) begin // M_END
					spi_scs <= 1'b1;
					spi_sdo <= 1'b0;
					state   <= M_IDLE;
				end
			endcase
		end
	end

	// Data shifter
	always_ff @(posedge clk_in) begin
		if (state == M_IDLE && spi_start)
			shift_reg <= {spi_word[14:0], 1'b0};
		else if (state == M_HIGH && half_done)
			shift_reg <= {shift_reg[14:0], 1'b0};
	end

endmodule

/* bench/adc_ctrl_tb.sv */
////////////////////
// Directed testbench for the ADC slow-control core
// SPI frames are rebuilt from the pins
// Clock manager model answers each phase step after 1 to 6 cycles
// Step delays come from a fixed seed
////////////////////

`timescale 1ns/10ps

module adc_ctrl_tb;

	localparam int SEED = 9099;
	localparam int STARTUP_WAIT = 256;
	localparam int PHASE_TARGET_INIT = 380;
	localparam int CENTER = 256;           // Phase after reset

	logic        clk_in;
	logic        rst_in;
	logic        cmd_trig;
	logic [15:0] cmd_addr;
	logic [15:0] cmd_data;
	logic        spi_scs, spi_sck, spi_sdo;
	logic        ps_en, ps_inc, ps_done, ps_locked;
	logic [8:0]  phase_value;

	int          cyc;                      // Cycles since reset release
	int          first_fall = -1;          // Cycle of first chip-select low
	int          bits = 0;
	int          up_cnt = 0;
	int          down_cnt = 0;
	int          err_cnt = 0;
	int          test_cnt = 0;
	int          fail_tests = 0;
	int unsigned dly;
	logic [15:0] shift_reg;
	logic [15:0] frames[$];                // Completed SPI frames

	clk_gen clk_gen_i (.clk_in, .rst_in);

	adc_ctrl_top #(.SPI_CLK_DIV(10), .STARTUP_WAIT(STARTUP_WAIT),
		.PHASE_TARGET_INIT(PHASE_TARGET_INIT)) dut_i (.*);

	always @(posedge clk_in or posedge rst_in)
		if (rst_in) cyc <= 0;
		else cyc <= cyc + 1;

	////////////////////
	// SPI monitor

	always @(negedge clk_in)
		if (first_fall < 0 && spi_scs === 1'b0) first_fall = cyc;

	always @(posedge spi_sck)
		if (spi_scs === 1'b0) begin
			shift_reg = {shift_reg[14:0], spi_sdo}; // MSB first
			bits++;
		end

	always @(posedge spi_scs)
		if (bits != 0) begin                        // Skips the reset edge
			assert (bits == 16) else begin
				$display("ERROR SPI frame ended after %0d clock edges", bits);
				err_cnt++;
			end
			frames.push_back(shift_reg);
			bits = 0;
		end

	////////////////////
	// Clock manager model
	initial begin
		ps_done = 1'b0;
		dly = $urandom(SEED);                       // Seed once
		forever begin
			@(negedge clk_in);
			if (ps_en === 1'b1) begin
				if (ps_inc) up_cnt++;
				else down_cnt++;
				dly = $urandom_range(5, 0);             // 1 to 6 cycles in total
				repeat (dly) @(negedge clk_in);
				ps_done = 1'b1;
				@(negedge clk_in);
				ps_done = 1'b0;
			end
		end
	end

	task automatic check_value(input string name, input int exp, input int act);
		assert (act == exp) else begin
			$display("FAILED %s: expected %0d (0x%0h), actual %0d (0x%0h)",
				name, exp, exp, act, act);
			err_cnt++;
		end
	endtask

	task automatic send_cmd(input logic [15:0] addr, input logic [15:0] data);
		@(negedge clk_in);
		cmd_trig = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge clk_in);
		cmd_trig = 1'b0;
	endtask

	task automatic wait_frames(input int n, input int limit);
		int t;
		t = 0;
		while (frames.size() < n && t < limit) begin
			@(negedge clk_in);
			t++;
		end
		assert (frames.size() >= n) else begin
			$display("ERROR timeout waiting for SPI frame %0d", n);
			err_cnt++;
		end
	endtask

	task automatic wait_phase(input logic [8:0] target, input int limit);
		int t;
		t = 0;
		while (phase_value !== target && t < limit) begin
			@(negedge clk_in);
			t++;
		end
		assert (phase_value === target) else begin
			$display("ERROR timeout waiting for phase %0d, still at %0d", target, phase_value);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		test_cnt++;
		if (err_cnt == errs_at_start) begin
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, err_cnt - errs_at_start);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic startup_writes();
		int e0;
		e0 = err_cnt;
		wait_frames(3, 4000);
		if (frames.size() >= 3) begin
			check_value("startup soft reset", 16'h0080, frames[0]);
			check_value("startup output format", 16'h0120, frames[1]);
			check_value("startup lane mode", 16'h0200, frames[2]);
		end
		assert (first_fall >= STARTUP_WAIT) else begin
			$display("ERROR chip select fell only %0d cycles after reset", first_fall);
			err_cnt++;
		end
		frames.delete();
		finish_test("startup_writes", e0);
	endtask

	task automatic initial_phase_move();
		int e0;
		e0 = err_cnt;
		wait_phase(9'(PHASE_TARGET_INIT), 3000);
		repeat (10) @(negedge clk_in);              // Any extra step shows up here
		check_value("initial phase", PHASE_TARGET_INIT, phase_value);
		check_value("initial up steps", PHASE_TARGET_INIT - CENTER, up_cnt);
		check_value("initial down steps", 0, down_cnt);
		finish_test("initial_phase_move", e0);
	endtask

	task automatic register_write();
		int e0;
		e0 = err_cnt;
		frames.delete();
		send_cmd(16'h31AB, 16'h1255);
		wait_frames(1, 1000);
		repeat (500) @(negedge clk_in);             // Room for a stray second frame
		check_value("reg write frame count", 1, frames.size());
		if (frames.size() > 0)
			check_value("reg write frame", 16'h2B55, frames[0]);
		finish_test("register_write", e0);
	endtask

	task automatic foreign_page_ignored();
		int         e0;
		int         steps;
		logic [8:0] ph;
		e0 = err_cnt;
		steps = up_cnt + down_cnt;
		ph = phase_value;
		frames.delete();
		send_cmd(16'h3310, 16'h00F0);
		repeat (1000) @(negedge clk_in);            // Observation window
		check_value("foreign page frames", 0, frames.size());
		check_value("foreign page steps", steps, up_cnt + down_cnt);
		check_value("foreign page phase", ph, phase_value);
		finish_test("foreign_page", e0);
	endtask

	task automatic commanded_move_lock();
		int e0;
		int t;
		e0 = err_cnt;
		up_cnt = 0;
		down_cnt = 0;
		send_cmd(16'h3200, 16'h00F0);
		t = 0;
		while (down_cnt < 20 && t < 1000) begin
			@(negedge clk_in);
			t++;
		end
		assert (down_cnt >= 20) else begin
			$display("ERROR phase stepping did not start after the command");
			err_cnt++;
		end
		ps_locked = 1'b0;                           // Lock lost mid move
		repeat (50) begin
			@(negedge clk_in);
			assert (ps_en !== 1'b1) else begin
				$display("ERROR ps_en pulsed while the clock manager was unlocked");
				err_cnt++;
			end
		end
		ps_locked = 1'b1;
		wait_phase(9'd240, 3000);
		repeat (10) @(negedge clk_in);
		check_value("commanded phase", 240, phase_value);
		check_value("commanded down steps", PHASE_TARGET_INIT - 240, down_cnt);
		check_value("commanded up steps", 0, up_cnt);
		finish_test("commanded_move_lock", e0);
	endtask

	initial begin
		int t;
		cmd_trig = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		ps_locked = 1'b1;                           // Locked from reset
		t = 0;
		while (rst_in !== 1'b0 && t < 100) begin
			@(negedge clk_in);
			t++;
		end
		assert (rst_in === 1'b0) else begin
			$display("ERROR reset was never released");
			err_cnt++;
		end
		startup_writes();
		initial_phase_move();
		register_write();
		foreign_page_ignored();
		commanded_move_lock();
		$display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bench/clk_gen.sv */
////////////////////
// Testbench clock, 40 ns period
// Reset held high for the first 8 cycles, released on a falling edge
////////////////////

`timescale 1ns/10ps

module clk_gen #(
	parameter int HALF_PERIOD  = 20,   // ns
	parameter int RESET_CYCLES = 8
) (
	output logic clk_in,
	output logic rst_in
);

	initial begin
		clk_in = 1'b0;
		rst_in = 1'b1;                            // Reset from time zero
		repeat (RESET_CYCLES) @(posedge clk_in);
		@(negedge clk_in);
		rst_in = 1'b0;                            // Away from the active edge
	end

	always #HALF_PERIOD clk_in = ~clk_in;

endmodule

/* build.f */
common/adc_ctrl_pkg.sv
src/adc_cmd_decode.sv
adc_config/adc_config_seq.sv
adc_config/spi_master.sv
src/enc_phase_ctrl.sv
src/adc_ctrl_top.sv
bench/clk_gen.sv
bench/adc_ctrl_tb.sv

/* common/adc_ctrl_pkg.sv */
////////////////////
// Shared widths and page codes of the ADC slow-control core
// SPI frames are write-only, 16 bits, MSB first
// Phase positions cover the full 9-bit range of the clock manager
////////////////////

package adc_ctrl_pkg;

	////////////////////
	// Host command fields
	typedef logic [15:0] cmd_addr_t;   // Command address
	typedef logic [15:0] cmd_data_t;   // Command data word
	typedef logic [7:0]  cmd_page_t;   // Address high byte

	// Page codes
	localparam cmd_page_t CMD_PAGE_SPI   = 8'h31; // ADC register write
	localparam cmd_page_t CMD_PAGE_PHASE = 8'h32; // Encode phase target

	////////////////////
	// ADC register access

	typedef logic [6:0] reg_addr_t;    // ADC register address
	typedef logic [7:0] reg_data_t;    // ADC register value

	// One SPI frame
	// Bit 15 write flag (0), bits 14:8 address, bits 7:0 value
	typedef logic [15:0] spi_word_t;

	////////////////////
	// Encode clock phase

	typedef logic [8:0] phase_t;       // Fine phase in taps

	localparam phase_t PHASE_CENTER = 9'd256; // Position after reset

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module adc_ctrl_tb -f build.f -o adc_ctrl_sim

out=$(./obj_dir/adc_ctrl_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "simulation did not pass"
exit 1

/* src/adc_cmd_decode.sv */
////////////////////
// Host command decoder
// Requests come out one cycle after cmd_trig
// Pages other than 0x31 and 0x32 are ignored
////////////////////

`timescale 1ns/10ps

module adc_cmd_decode (
	input  logic                     clk_in,
	input  logic                     rst_in,
	input  logic                     cmd_trig,     // One-cycle strobe
	input  adc_ctrl_pkg::cmd_addr_t  cmd_addr,
	input  adc_ctrl_pkg::cmd_data_t  cmd_data,
	output logic                     reg_req,      // To config sequencer
	output adc_ctrl_pkg::reg_addr_t  reg_addr,
	output adc_ctrl_pkg::reg_data_t  reg_data,
	output logic                     phase_req,    // To phase controller
	output adc_ctrl_pkg::phase_t     phase_target
);

	adc_ctrl_pkg::cmd_page_t page;
	assign page = cmd_addr[15:8]; // High byte picks the function

	// Request pulses
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			reg_req   <= 1'b0;
			phase_req <= 1'b0;
		end else begin
			reg_req   <= cmd_trig && (page == adc_ctrl_pkg::CMD_PAGE_SPI);
			phase_req <= cmd_trig && (page == adc_ctrl_pkg::CMD_PAGE_PHASE);
		end
	end

	// Payload, only meaningful alongside a pulse
	always_ff @(posedge clk_in) begin
		if (cmd_trig) begin
			reg_addr     <= cmd_addr[6:0]; // Low 7 address bits
			reg_data     <= cmd_data[7:0];
			phase_target <= cmd_data[8:0]; // Target in taps
		end
	end

endmodule

/* src/adc_ctrl_top.sv */
////////////////////
// Slow-control core for a dual-channel serial LVDS ADC
// Phase shift port runs on clk_in, clock manager is external
// SPI is write-only, no readback
////////////////////

`timescale 1ns/10ps

module adc_ctrl_top #(
	parameter int SPI_CLK_DIV       = 10,   // sck half period in cycles
	parameter int STARTUP_WAIT      = 256,  // Delay before init writes
	parameter int PHASE_TARGET_INIT = 380   // Encode phase after reset
) (
	input  logic                     clk_in,
	input  logic                     rst_in,
	input  logic                     cmd_trig,
	input  adc_ctrl_pkg::cmd_addr_t  cmd_addr,
	input  adc_ctrl_pkg::cmd_data_t  cmd_data,
	output logic                     spi_scs,
	output logic                     spi_sck,
	output logic                     spi_sdo,
	output logic                     ps_en,
	output logic                     ps_inc,
	input  logic                     ps_done,
	input  logic                     ps_locked,
	output adc_ctrl_pkg::phase_t     phase_value
);

	// Decoder outputs
	logic                     reg_req;
	adc_ctrl_pkg::reg_addr_t  reg_addr;
	adc_ctrl_pkg::reg_data_t  reg_data;
	logic                     phase_req;
	adc_ctrl_pkg::phase_t     phase_target;
	// Sequencer to SPI master
	logic                     spi_start;
	adc_ctrl_pkg::spi_word_t  spi_word;
	logic                     spi_ready;

	adc_cmd_decode cmd_decode_i (.clk_in, .rst_in, .cmd_trig, .cmd_addr, .cmd_data,
		.reg_req, .reg_addr, .reg_data, .phase_req, .phase_target);

	adc_config_seq #(.STARTUP_WAIT(STARTUP_WAIT)) config_seq_i (.clk_in, .rst_in,
		.reg_req, .reg_addr, .reg_data, .spi_start, .spi_word, .spi_ready);

	spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) spi_master_i (.clk_in, .rst_in,
		.spi_start, .spi_word, .spi_ready, .spi_scs, .spi_sck, .spi_sdo);

	enc_phase_ctrl #(.PHASE_TARGET_INIT(PHASE_TARGET_INIT)) phase_ctrl_i (.clk_in, .rst_in,
		.phase_req, .phase_target, .ps_en, .ps_inc, .ps_done, .ps_locked, .phase_value);

endmodule

/* src/enc_phase_ctrl.sv */
////////////////////
// Encode clock fine phase controller
// Steps one tap at a time, waits for ps_done after each step
// No stepping while the clock manager is unlocked
// Range clamps at 0 and 511
////////////////////

`timescale 1ns/10ps

module enc_phase_ctrl #(
	parameter int PHASE_TARGET_INIT = 380   // Target after reset
) (
	input  logic                  clk_in,
	input  logic                  rst_in,
	input  logic                  phase_req,     // New target strobe
	input  adc_ctrl_pkg::phase_t  phase_target,
	output logic                  ps_en,         // One-cycle step request
	output logic                  ps_inc,        // 1 = one tap later
	input  logic                  ps_done,
	input  logic                  ps_locked,
	output adc_ctrl_pkg::phase_t  phase_value    // Current position
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_DECIDE,
		P_STEP,
		P_WAIT
	} ps_state_t;

	ps_state_t            state;
	adc_ctrl_pkg::phase_t target;    // Where we are heading
	logic                 go_up;
	logic                 go_down;

	// Clamp to the full 9-bit range
	assign go_up   = (phase_value < target) && (phase_value != '1);
	assign go_down = (phase_value > target) && (phase_value != '0);

	////////////////////
	// Stepping FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state       <= P_DECIDE; // Move to the initial target right away
			target      <= adc_ctrl_pkg::phase_t'(PHASE_TARGET_INIT);
			phase_value <= adc_ctrl_pkg::PHASE_CENTER;
			ps_en       <= 1'b0;
			ps_inc      <= 1'b0;
		end else begin
			ps_en <= 1'b0; // Pulse by default
			case (state)
				P_IDLE: begin
					if (phase_req) begin
						target <= phase_target;
						state  <= P_DECIDE;
					end
				end
				P_DECIDE: begin
					if (ps_locked) begin // Hold here until lock
						if (go_up || go_down) begin
							ps_inc <= go_up;
							state  <= P_STEP;
						end else begin
							state <= P_IDLE;
						end
					end
				end
				P_STEP: begin
					if (ps_locked) begin
						ps_en <= 1'b1;
						state <= P_WAIT;
					end else begin
						state <= P_DECIDE; // Lock lost, start over
					end
				end
				default: begin // P_WAIT
					if (ps_done) begin
						phase_value <= ps_inc ? phase_value + 1'b1 : phase_value - 1'b1;
						state       <= P_DECIDE;
					end
				end
			endcase
		end
	end

endmodule
